/* filelist.f */
design/axicb_cfg_pkg.sv
design/axi_rd_pkg.sv
design/axicb_pipeline.sv
design/axicb_rr_arbiter.sv
design/axicb_slv_switch.sv
design/axicb_mst_switch.sv
design/axicb_switch_top.sv
tb/tb_clkgen.sv
tb/tb_axicb_switch.sv

/* run.sh */
#!/bin/sh
# Build and run the crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_axicb_switch -f filelist.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
    exit 0
else
    echo "simulation reported errors, see sim.log"
    exit 1
fi

/* tb/tb_axicb_switch.sv */
//////////////////////////////////////////////////////////////////////
// Crossbar testbench: master and slave models, scoreboard counters,
// concurrent assertions and reporting
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_axicb_switch
    import axicb_cfg_pkg::*;
    import axi_rd_pkg::*;
();

    localparam int N_MIX      = 24;
    localparam int N_DEC      = 16;
    localparam int N_FAIR     = 24;
    localparam int N_RD       = N_MIX + N_DEC + N_FAIR;
    localparam int MAX_CYCLES = 4 * (MST_NB * N_RD) * 20;

    logic                aclk;
    logic                rst;
    logic [MST_NB-1:0]   mst_arvalid = '0;
    logic [MST_NB-1:0]   mst_arready;
    ar_ch_t [MST_NB-1:0] mst_ar      = '0;
    logic [MST_NB-1:0]   mst_rvalid;
    logic [MST_NB-1:0]   mst_rready  = '0;
    r_ch_t [MST_NB-1:0]  mst_r;
    logic [SLV_NB-1:0]   slv_arvalid;
    logic [SLV_NB-1:0]   slv_arready = '0;
    ar_ch_t [SLV_NB-1:0] slv_ar;
    logic [SLV_NB-1:0]   slv_rvalid  = '0;
    logic [SLV_NB-1:0]   slv_rready;
    r_ch_t [SLV_NB-1:0]  slv_r       = '0;

    // Read lists and the indices of the reads that reach a slave
    logic [ADDR_W-1:0] rd_addr [MST_NB][N_RD];
    logic [ID_W-1:0]   rd_id   [MST_NB][N_RD];
    int                map_idx [MST_NB][N_RD];
    int                map_cnt [MST_NB];

    int  seed    = 32943;
    int  err_cnt = 0;
    int  iss_lim = 0;
    bit  calm    = 1'b0;
    bit  fair_on = 1'b0;
    int  cycles  = 0;
    int  iss_cnt  [MST_NB];
    int  rsp_cnt  [MST_NB];
    int  fwd_cnt  [MST_NB];
    int  srsp_cnt [MST_NB];
    int  run_len  [SLV_NB];
    logic [MST_IDX_W-1:0] run_mst [SLV_NB];
    logic                 both_queued;
    ar_ch_t               slv_fifo [SLV_NB][16];
    logic [3:0]           wp [SLV_NB];
    logic [3:0]           rp [SLV_NB];

    tb_clkgen #(.PERIOD_NS(10), .RST_CYCLES(4)) u_clkgen (
        .o_clk (aclk),
        .o_rst (rst)
    );

    axicb_switch_top u_axicb_switch_top (
        .aclk          (aclk),
        .i_rst         (rst),
        .i_mst_arvalid (mst_arvalid),
        .o_mst_arready (mst_arready),
        .i_mst_ar      (mst_ar),
        .o_mst_rvalid  (mst_rvalid),
        .i_mst_rready  (mst_rready),
        .o_mst_r       (mst_r),
        .o_slv_arvalid (slv_arvalid),
        .i_slv_arready (slv_arready),
        .o_slv_ar      (slv_ar),
        .i_slv_rvalid  (slv_rvalid),
        .o_slv_rready  (slv_rready),
        .i_slv_r       (slv_r)
    );

    ///////////////////////////////////////////////////////////////////
    // Reference rules
    ///////////////////////////////////////////////////////////////////

    function automatic logic coin(int pct);
        int v;
        v = $random(seed) % 100;
        if (v < 0) v = -v;
        return v < pct;
    endfunction

    // Slave index for an address or -1 when unmapped
    function automatic int slave_of(logic [ADDR_W-1:0] addr);
        if (addr <= SLV0_END) return 0;
        if (addr >= SLV1_START && addr <= SLV1_END) return 1;
        return -1;
    endfunction

    function automatic logic [ID_W-1:0] tag_id(int m, logic [ID_W-1:0] id);
        logic [ID_W-1:0] t;
        t = id;
        t[MST_ID_BIT] = m[0];
        return t;
    endfunction

    // fwd is the number of ARs of that master already seen at a slave
    function automatic bit ar_expected(ar_ch_t ar, int fwd);
        int     m;
        int     n;
        ar_ch_t e;
        m = int'(ar.id[MST_ID_BIT]);
        if (fwd >= map_cnt[m]) return 1'b0;
        n      = map_idx[m][fwd];
        e.id   = tag_id(m, rd_id[m][n]);
        e.addr = rd_addr[m][n];
        return ar == e;
    endfunction

    // n is the position of this response in the master's R stream
    function automatic bit r_expected(int m, int n, r_ch_t r);
        r_ch_t e;
        int    k;
        if (n >= N_RD) return 1'b0;
        k      = slave_of(rd_addr[m][n]);
        e.id   = tag_id(m, rd_id[m][n]);
        e.last = 1'b1;
        if (k < 0) begin
            e.data = '0;
            e.resp = RESP_DECERR;
        end else begin
            e.data = {8'(k), 8'h00, rd_addr[m][n]};
            e.resp = RESP_OKAY;
        end
        return r == e;
    endfunction

    task automatic report_mismatch(string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    ///////////////////////////////////////////////////////////////////
    // Master models
    ///////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        int nxt;
        for (int m = 0; m < MST_NB; m++) begin
            if (rst) begin
                mst_arvalid[m] <= 1'b0;
                mst_rready[m]  <= 1'b0;
                iss_cnt[m]     <= 0;
            end else begin
                nxt = iss_cnt[m];
                if (mst_arvalid[m] && mst_arready[m]) nxt = nxt + 1;
                iss_cnt[m] <= nxt;
                // A pending AR stays put until it is taken
                if (!(mst_arvalid[m] && !mst_arready[m])) begin
                    if (nxt < iss_lim) begin
                        mst_arvalid[m] <= 1'b1;
                        mst_ar[m]      <= {rd_id[m][nxt], rd_addr[m][nxt]};
                    end else begin
                        mst_arvalid[m] <= 1'b0;
                    end
                end
                mst_rready[m] <= calm ? 1'b1 : coin(60);
            end
        end
    end

    ///////////////////////////////////////////////////////////////////
    // Slave models returning in-order R after a random delay
    ///////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        ar_ch_t head;
        r_ch_t  rsp;
        for (int s = 0; s < SLV_NB; s++) begin
            if (rst) begin
                slv_arready[s] <= 1'b0;
                slv_rvalid[s]  <= 1'b0;
                wp[s]          <= '0;
                rp[s]          <= '0;
            end else begin
                if (slv_arvalid[s] && slv_arready[s]) begin
                    slv_fifo[s][wp[s]] <= slv_ar[s];
                    wp[s]              <= wp[s] + 1'b1;
                end
                slv_arready[s] <= coin(70);
                if (!slv_rvalid[s] || slv_rready[s]) begin
                    if (rp[s] != wp[s] && (calm || coin(50))) begin
                        head     = slv_fifo[s][rp[s]];
                        rsp.id   = head.id;
                        rsp.data = {8'(s), 8'h00, head.addr};
                        rsp.resp = RESP_OKAY;
                        rsp.last = 1'b1;
                        slv_r[s]      <= rsp;
                        slv_rvalid[s] <= 1'b1;
                        rp[s]         <= rp[s] + 1'b1;
                    end else begin
                        slv_rvalid[s] <= 1'b0;
                    end
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////
    // Transfer counters and AR run lengths per slave
    ///////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        logic [MST_IDX_W-1:0] mi;
        if (rst) begin
            for (int m = 0; m < MST_NB; m++) begin
                rsp_cnt[m]  <= 0;
                fwd_cnt[m]  <= 0;
                srsp_cnt[m] <= 0;
            end
        end else begin
            for (int m = 0; m < MST_NB; m++) begin
                if (mst_rvalid[m] && mst_rready[m]) rsp_cnt[m] <= rsp_cnt[m] + 1;
            end
            for (int s = 0; s < SLV_NB; s++) begin
                if (slv_arvalid[s] && slv_arready[s]) begin
                    mi          = slv_ar[s].id[MST_ID_BIT];
                    fwd_cnt[mi] <= fwd_cnt[mi] + 1;
                end
                if (slv_rvalid[s] && slv_rready[s]) begin
                    mi           = slv_r[s].id[MST_ID_BIT];
                    srsp_cnt[mi] <= srsp_cnt[mi] + 1;
                end
            end
        end
    end

    always @(posedge aclk) begin
        for (int s = 0; s < SLV_NB; s++) begin
            if (!fair_on) begin
                run_len[s] <= 0;
            end else if (slv_arvalid[s] && slv_arready[s]) begin
                if (run_len[s] > 0 && run_mst[s] == slv_ar[s].id[MST_ID_BIT]) begin
                    run_len[s] <= run_len[s] + 1;
                end else begin
                    run_mst[s] <= slv_ar[s].id[MST_ID_BIT];
                    run_len[s] <= 1;
                end
            end
        end
    end

    always_comb begin
        both_queued = 1'b1;
        for (int m = 0; m < MST_NB; m++) begin
            if (iss_cnt[m] >= iss_lim) both_queued = 1'b0;
        end
    end

    ///////////////////////////////////////////////////////////////////
    // Checks
    ///////////////////////////////////////////////////////////////////

    for (genvar s = 0; s < SLV_NB; s++) begin : g_slv_chk
        a_range: assert property (@(posedge aclk) disable iff (rst)
            slv_arvalid[s] |-> slave_of(slv_ar[s].addr) == s)
            else report_mismatch($sformatf("slave %0d saw addr %h", s, slv_ar[s].addr));

        // Unmapped reads are missing from the map list, so they fail here too
        a_ar_order: assert property (@(posedge aclk) disable iff (rst)
            slv_arvalid[s] && slv_arready[s] |->
                ar_expected(slv_ar[s], fwd_cnt[slv_ar[s].id[MST_ID_BIT]]))
            else report_mismatch($sformatf("slave %0d AR id %h addr %h not expected",
                                           s, slv_ar[s].id, slv_ar[s].addr));

        a_fair: assert property (@(posedge aclk) disable iff (rst)
            fair_on && both_queued && slv_arvalid[s] && slv_arready[s] |->
                !(run_len[s] >= 2 && run_mst[s] == slv_ar[s].id[MST_ID_BIT]))
            else report_mismatch($sformatf("slave %0d served master %0d three times in a row",
                                           s, run_mst[s]));
    end

    for (genvar m = 0; m < MST_NB; m++) begin : g_mst_chk
        a_r_order: assert property (@(posedge aclk) disable iff (rst)
            mst_rvalid[m] && mst_rready[m] |-> r_expected(m, rsp_cnt[m], mst_r[m]))
            else report_mismatch($sformatf("master %0d R #%0d id %h data %h resp %0d last %0d",
                                           m, rsp_cnt[m], mst_r[m].id, mst_r[m].data,
                                           mst_r[m].resp, mst_r[m].last));

        a_r_extra: assert property (@(posedge aclk) disable iff (rst)
            mst_rvalid[m] |-> rsp_cnt[m] < iss_cnt[m])
        else begin
            $display("Error at %0t: master %0d got a response with no read pending", $time, m);
            err_cnt++;
        end

        a_ostd: assert property (@(posedge aclk) disable iff (rst)
            fwd_cnt[m] - srsp_cnt[m] <= OSTD_MAX)
            else report_mismatch($sformatf("master %0d has %0d reads in flight",
                                           m, fwd_cnt[m] - srsp_cnt[m]));
    end

    ///////////////////////////////////////////////////////////////////
    // Test sequence
    ///////////////////////////////////////////////////////////////////

    // Mixed slaves, then half unmapped, then everything to slave 0
    task automatic gen_reads();
        int k;
        for (int m = 0; m < MST_NB; m++) begin
            map_cnt[m] = 0;
            for (int n = 0; n < N_RD; n++) begin
                if (n < N_MIX) begin
                    k = coin(12) ? -1 : int'(coin(50));
                end else if (n < N_MIX + N_DEC) begin
                    k = coin(50) ? -1 : int'(coin(50));
                end else begin
                    k = 0;
                end
                rd_id[m][n] = ID_W'($random(seed));
                if (k < 0) begin
                    rd_addr[m][n] = 16'h2000 | ADDR_W'($random(seed));
                end else begin
                    rd_addr[m][n]         = {4'(k), 12'($random(seed))};
                    map_idx[m][map_cnt[m]] = n;
                    map_cnt[m]++;
                end
            end
        end
    endtask

    function automatic bit all_done();
        for (int m = 0; m < MST_NB; m++) begin
            if (rsp_cnt[m] != iss_lim) return 1'b0;
        end
        return 1'b1;
    endfunction

    int tests_run    = 0;
    int tests_failed = 0;

    task automatic run_test(string name, int n, bit contend);
        int err0;
        err0 = err_cnt;
        @(posedge aclk);
        calm    <= contend;
        fair_on <= contend;
        iss_lim <= iss_lim + n;
        do @(posedge aclk); while (!all_done());
        calm    <= 1'b0;
        fair_on <= 1'b0;
        tests_run++;
        if (err_cnt != err0) tests_failed++;
        $display("Test %0s: %0d reads per master, %0d errors", name, n, err_cnt - err0);
    endtask

    initial begin
        gen_reads();
        @(posedge aclk);
        while (rst) @(posedge aclk);
        run_test("random traffic", N_MIX, 1'b0);
        run_test("decode errors", N_DEC, 1'b0);
        run_test("slave contention", N_FAIR, 1'b1);
        // Quiet tail to catch stray responses
        repeat (20) @(posedge aclk);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

endmodule

/* tb/tb_clkgen.sv */
//////////////////////////////////////////////////////////////////////
// Testbench clock generator and reset sequencer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset held over the first few rising edges
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

/* design/axicb_switch_top.sv */
//////////////////////////////////////////////////////////////////////
// Read-only crossbar top: master slices, both switch arrays and the
// handshake reordering between them
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axicb_switch_top
    import axicb_cfg_pkg::*;
    import axi_rd_pkg::*;
(
    input  logic                   aclk,
    input  logic                   i_rst,
    // Master ports
    input  logic   [MST_NB-1:0]    i_mst_arvalid,
    output logic   [MST_NB-1:0]    o_mst_arready,
    input  ar_ch_t [MST_NB-1:0]    i_mst_ar,
    output logic   [MST_NB-1:0]    o_mst_rvalid,
    input  logic   [MST_NB-1:0]    i_mst_rready,
    output r_ch_t  [MST_NB-1:0]    o_mst_r,
    // Slave ports
    output logic   [SLV_NB-1:0]    o_slv_arvalid,
    input  logic   [SLV_NB-1:0]    i_slv_arready,
    output ar_ch_t [SLV_NB-1:0]    o_slv_ar,
    input  logic   [SLV_NB-1:0]    i_slv_rvalid,
    output logic   [SLV_NB-1:0]    o_slv_rready,
    input  r_ch_t  [SLV_NB-1:0]    i_slv_r
);

    // Master-major handshakes, seen from the per-master switches
    logic [MST_NB*SLV_NB-1:0] sw_arvalid;
    logic [MST_NB*SLV_NB-1:0] sw_arready;
    logic [MST_NB*SLV_NB-1:0] sw_rvalid;
    logic [MST_NB*SLV_NB-1:0] sw_rready;
    // Slave-major handshakes, seen from the per-slave switches
    logic [MST_NB*SLV_NB-1:0] xb_arvalid;
    logic [MST_NB*SLV_NB-1:0] xb_arready;
    logic [MST_NB*SLV_NB-1:0] xb_rvalid;
    logic [MST_NB*SLV_NB-1:0] xb_rready;
    ar_ch_t [MST_NB-1:0]      sw_ar;
    r_ch_t  [SLV_NB-1:0]      xb_r;

    genvar i, j;

    ///////////////////////////////////////////////////////////////////
    // Master side
    ///////////////////////////////////////////////////////////////////

    for (i = 0; i < MST_NB; i++) begin : g_mst
        logic   pipe_arvalid;
        logic   pipe_arready;
        ar_ch_t pipe_ar;
        logic   pipe_rvalid;
        logic   pipe_rready;
        r_ch_t  pipe_r;

        axicb_pipeline #(.T(ar_ch_t)) u_ar_pipe (
            .aclk    (aclk),
            .i_rst   (i_rst),
            .i_valid (i_mst_arvalid[i]),
            .i_data  (i_mst_ar[i]),
            .o_ready (o_mst_arready[i]),
            .o_valid (pipe_arvalid),
            .o_data  (pipe_ar),
            .i_ready (pipe_arready)
        );

        axicb_pipeline #(.T(r_ch_t)) u_r_pipe (
            .aclk    (aclk),
            .i_rst   (i_rst),
            .i_valid (pipe_rvalid),
            .i_data  (pipe_r),
            .o_ready (pipe_rready),
            .o_valid (o_mst_rvalid[i]),
            .o_data  (o_mst_r[i]),
            .i_ready (i_mst_rready[i])
        );

        axicb_slv_switch #(.MST_IDX(i)) u_slv_switch (
            .aclk          (aclk),
            .i_rst         (i_rst),
            .i_arvalid     (pipe_arvalid),
            .i_ar          (pipe_ar),
            .o_arready     (pipe_arready),
            .o_rvalid      (pipe_rvalid),
            .o_r           (pipe_r),
            .i_rready      (pipe_rready),
            .o_slv_arvalid (sw_arvalid[i*SLV_NB +: SLV_NB]),
            .o_slv_ar      (sw_ar[i]),
            .i_slv_arready (sw_arready[i*SLV_NB +: SLV_NB]),
            .i_slv_rvalid  (sw_rvalid[i*SLV_NB +: SLV_NB]),
            .i_slv_r       (xb_r),
            .o_slv_rready  (sw_rready[i*SLV_NB +: SLV_NB])
        );
    end

    ///////////////////////////////////////////////////////////////////
    // Transpose master-major vectors into slave-major ones
    ///////////////////////////////////////////////////////////////////

    for (i = 0; i < MST_NB; i++) begin : g_xpose_mst
        for (j = 0; j < SLV_NB; j++) begin : g_xpose_slv
            assign xb_arvalid[j*MST_NB+i] = sw_arvalid[i*SLV_NB+j];
            assign xb_rready[j*MST_NB+i]  = sw_rready[i*SLV_NB+j];
            assign sw_arready[i*SLV_NB+j] = xb_arready[j*MST_NB+i];
            assign sw_rvalid[i*SLV_NB+j]  = xb_rvalid[j*MST_NB+i];
        end
    end

    ///////////////////////////////////////////////////////////////////
    // Slave side
    ///////////////////////////////////////////////////////////////////

    for (j = 0; j < SLV_NB; j++) begin : g_slv
        axicb_mst_switch u_mst_switch (
            .aclk          (aclk),
            .i_rst         (i_rst),
            .i_arvalid     (xb_arvalid[j*MST_NB +: MST_NB]),
            .i_ar          (sw_ar),
            .o_arready     (xb_arready[j*MST_NB +: MST_NB]),
            .o_rvalid      (xb_rvalid[j*MST_NB +: MST_NB]),
            .o_r           (xb_r[j]),
            .i_rready      (xb_rready[j*MST_NB +: MST_NB]),
            .o_slv_arvalid (o_slv_arvalid[j]),
            .o_slv_ar      (o_slv_ar[j]),
            .i_slv_arready (i_slv_arready[j]),
            .i_slv_rvalid  (i_slv_rvalid[j]),
            .i_slv_r       (i_slv_r[j]),
            .o_slv_rready  (o_slv_rready[j])
        );
    end

endmodule

/* design/axicb_mst_switch.sv */
//////////////////////////////////////////////////////////////////////
// Slave-side switch: round-robin AR arbitration among masters and
// R routing back to the master named in the ID
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axicb_mst_switch
    import axicb_cfg_pkg::*;
    import axi_rd_pkg::*;
(
    input  logic                     aclk,
    input  logic                     i_rst,
    // From the per-master switches
    input  logic   [MST_NB-1:0]      i_arvalid,
    input  ar_ch_t [MST_NB-1:0]      i_ar,
    output logic   [MST_NB-1:0]      o_arready,
    output logic   [MST_NB-1:0]      o_rvalid,
    output r_ch_t                    o_r,
    input  logic   [MST_NB-1:0]      i_rready,
    // Slave port
    output logic                     o_slv_arvalid,
    output ar_ch_t                   o_slv_ar,
    input  logic                     i_slv_arready,
    input  logic                     i_slv_rvalid,
    input  r_ch_t                    i_slv_r,
    output logic                     o_slv_rready
);

    logic              busy_q;
    logic [MST_NB-1:0] grant_q;
    logic [MST_NB-1:0] arb_req;
    logic [MST_NB-1:0] grant;
    logic [MST_NB-1:0] dst_oh;
    logic              ar_fire;

    ///////////////////////////////////////////////////////////////////
    // AR arbitration
    ///////////////////////////////////////////////////////////////////

    // A stalled request keeps its grant so the slave sees a stable AR
    assign arb_req = busy_q ? grant_q : i_arvalid;

    axicb_rr_arbiter u_rr_arbiter (
        .aclk      (aclk),
        .i_rst     (i_rst),
        .i_req     (arb_req),
        .i_advance (ar_fire),
        .o_grant   (grant)
    );

    always_comb begin
        o_slv_ar = '0;
        for (int m = 0; m < MST_NB; m++) begin
            if (grant[m]) begin
                o_slv_ar = i_ar[m];
            end
        end
    end

    assign o_slv_arvalid = |(i_arvalid & grant);
    assign o_arready     = grant & {MST_NB{i_slv_arready}};
    assign ar_fire       = o_slv_arvalid && i_slv_arready;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= o_slv_arvalid && !i_slv_arready;
        end
    end

    always_ff @(posedge aclk) begin
        grant_q <= grant;
    end

    ///////////////////////////////////////////////////////////////////
    // R routing
    ///////////////////////////////////////////////////////////////////

    // Master index travels in the echoed ID
    assign dst_oh = MST_NB'(1) << i_slv_r.id[MST_ID_BIT];

    assign o_rvalid     = dst_oh & {MST_NB{i_slv_rvalid}};
    assign o_r          = i_slv_r;
    assign o_slv_rready = |(dst_oh & i_rready);

endmodule

/* design/axicb_slv_switch.sv */
//////////////////////////////////////////////////////////////////////
// Master-side switch: address decode, outstanding read tracking,
// decode-error responder and read data selection
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axicb_slv_switch
    import axicb_cfg_pkg::*;
    import axi_rd_pkg::*;
#(
    parameter int MST_IDX = 0
) (
    input  logic                     aclk,
    input  logic                     i_rst,
    // From the master slices
    input  logic                     i_arvalid,
    input  ar_ch_t                   i_ar,
    output logic                     o_arready,
    output logic                     o_rvalid,
    output r_ch_t                    o_r,
    input  logic                     i_rready,
    // Toward the per-slave switches
    output logic [SLV_NB-1:0]        o_slv_arvalid,
    output ar_ch_t                   o_slv_ar,
    input  logic [SLV_NB-1:0]        i_slv_arready,
    input  logic [SLV_NB-1:0]        i_slv_rvalid,
    input  r_ch_t  [SLV_NB-1:0]      i_slv_r,
    output logic [SLV_NB-1:0]        o_slv_rready
);

    logic [SLV_NB-1:0]     hit;
    logic [OSTD_CNT_W-1:0] ostd_cnt;
    logic [SLV_NB-1:0]     tgt_q;
    logic                  err_valid;
    logic [ID_W-1:0]       err_id;
    logic                  ostd_room;
    logic                  same_tgt;
    logic                  map_go;
    logic                  err_go;
    logic                  ar_fire;
    logic                  r_fire;
    ar_ch_t                ar_tagged;

    ///////////////////////////////////////////////////////////////////
    // Read address path
    ///////////////////////////////////////////////////////////////////

    assign hit[0] = (i_ar.addr >= SLV0_START) && (i_ar.addr <= SLV0_END);
    assign hit[1] = (i_ar.addr >= SLV1_START) && (i_ar.addr <= SLV1_END);

    // Stamp the master index into the ID so R can find its way back
    always_comb begin
        ar_tagged                 = i_ar;
        ar_tagged.id[MST_ID_BIT] = 1'(MST_IDX);
    end

    assign ostd_room = ostd_cnt < OSTD_CNT_W'(OSTD_MAX);
    // Switching target only once every earlier read has returned
    assign same_tgt  = (ostd_cnt == '0) || (hit == tgt_q);

    assign map_go = i_arvalid && (|hit) && ostd_room && same_tgt;
    // Unmapped reads wait for an empty pipe, then get answered locally
    assign err_go = i_arvalid && !(|hit) && (ostd_cnt == '0);

    assign o_slv_arvalid = hit & {SLV_NB{map_go}};
    assign o_slv_ar      = ar_tagged;
    assign o_arready     = err_go || (|(o_slv_arvalid & i_slv_arready));
    assign ar_fire       = i_arvalid && o_arready;

    ///////////////////////////////////////////////////////////////////
    // Read data path
    ///////////////////////////////////////////////////////////////////

    always_comb begin
        o_r = '0;
        for (int s = 0; s < SLV_NB; s++) begin
            if (tgt_q[s]) begin
                o_r = i_slv_r[s];
            end
        end
        if (err_valid) begin
            o_r.id   = err_id;
            o_r.data = '0;
            o_r.resp = RESP_DECERR;
            o_r.last = 1'b1;
        end
    end

    // tgt_q is all zero while an error response is pending
    assign o_rvalid     = err_valid || (|(i_slv_rvalid & tgt_q));
    assign o_slv_rready = tgt_q & {SLV_NB{i_rready}};
    assign r_fire       = o_rvalid && i_rready;

    // The error response counts as an outstanding read too
    always_ff @(posedge aclk) begin
        if (i_rst) begin
            ostd_cnt  <= '0;
            tgt_q     <= '0;
            err_valid <= 1'b0;
        end else begin
            if (ar_fire && !r_fire) begin
                ostd_cnt <= ostd_cnt + 1'b1;
            end else if (!ar_fire && r_fire) begin
                ostd_cnt <= ostd_cnt - 1'b1;
            end
            if (ar_fire) begin
                tgt_q <= hit;
            end
            if (err_go) begin
                err_valid <= 1'b1;
            end else if (r_fire && err_valid) begin
                err_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (err_go) begin
            err_id <= ar_tagged.id;
        end
    end

endmodule

/* design/axicb_rr_arbiter.sv */
//////////////////////////////////////////////////////////////////////
// Round-robin arbiter among masters with a rotating priority pointer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axicb_rr_arbiter
    import axicb_cfg_pkg::*;
(
    input  logic              aclk,
    input  logic              i_rst,
    input  logic [MST_NB-1:0] i_req,
    input  logic              i_advance,
    output logic [MST_NB-1:0] o_grant
);

    logic [MST_IDX_W-1:0] ptr;
    logic [MST_IDX_W-1:0] cand;
    logic [MST_IDX_W-1:0] gnt_idx;
    logic                 found;

    // First requester at or after the pointer wins
    always_comb begin
        o_grant = '0;
        gnt_idx = '0;
        cand    = '0;
        found   = 1'b0;
        for (int k = 0; k < MST_NB; k++) begin
            cand = MST_IDX_W'((int'(ptr) + k) % MST_NB);
            if (!found && i_req[cand]) begin
                o_grant[cand] = 1'b1;
                gnt_idx       = cand;
                found         = 1'b1;
            end
        end
    end

    ///////////////////////////////////////////////////////////////////
    // Pointer moves just past the master that got served
    ///////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            ptr <= '0;
        end else if (i_advance && found) begin
            ptr <= (int'(gnt_idx) == MST_NB - 1) ? '0 : gnt_idx + 1'b1;
        end
    end

endmodule

/* design/axicb_pipeline.sv */
//////////////////////////////////////////////////////////////////////
// Two-entry valid/ready register slice for any payload type
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axicb_pipeline #(
    parameter type T = logic [7:0]
) (
    input  logic aclk,
    input  logic i_rst,
    // Upstream side
    input  logic i_valid,
    input  T     i_data,
    output logic o_ready,
    // Downstream side
    output logic o_valid,
    output T     o_data,
    input  logic i_ready
);

    logic skid_valid;
    T     skid_data;

    // Registered ready, no path from i_ready back to o_ready
    assign o_ready = !skid_valid;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            o_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!o_valid || i_ready) begin
            // Output slot frees up, skid entry has priority
            if (skid_valid) begin
                o_valid    <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                o_valid <= i_valid;
            end
        end else if (i_valid && !skid_valid) begin
            // Output stalled, park the incoming beat
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!o_valid || i_ready) begin
            o_data <= skid_valid ? skid_data : i_data;
        end
        if (o_valid && !i_ready && i_valid && !skid_valid) begin
            skid_data <= i_data;
        end
    end

endmodule

/* design/axi_rd_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Payload types of the AXI read address and read data channels
//////////////////////////////////////////////////////////////////////

package axi_rd_pkg;

    import axicb_cfg_pkg::*;

    // AR channel payload, 20 bits
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
    } ar_ch_t;

    // R channel payload, 39 bits
    // Single-beat bursts only, so last is always set
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
        logic              last;
    } r_ch_t;

endpackage

/* design/axicb_cfg_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Crossbar configuration: sizes, slave address map, outstanding
// limit and AXI response codes
//////////////////////////////////////////////////////////////////////

package axicb_cfg_pkg;

    // Crossbar dimensions
    localparam int MST_NB    = 2;
    localparam int SLV_NB    = 2;
    localparam int MST_IDX_W = $clog2(MST_NB);

    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int RESP_W = 2;

    // ID bit that carries the master index toward the slaves
    localparam int MST_ID_BIT = 3;

    // Slave address map, anything from 0x2000 up is unmapped
    localparam logic [ADDR_W-1:0] SLV0_START = 16'h0000;
    localparam logic [ADDR_W-1:0] SLV0_END   = 16'h0FFF;
    localparam logic [ADDR_W-1:0] SLV1_START = 16'h1000;
    localparam logic [ADDR_W-1:0] SLV1_END   = 16'h1FFF;

    // Reads in flight per master
    localparam int OSTD_MAX   = 4;
    localparam int OSTD_CNT_W = 3;

    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
    localparam logic [RESP_W-1:0] RESP_DECERR = 2'd3;

endpackage
